/* Makefile */
VERILATOR ?= verilator
TOP       ?= control_unit_tb
LOG       ?= sim.log
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter %.sv,$(shell cat $(FILELIST)))
HEADERS := include/decode_model.svh

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -qx '>>> PASS' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* include/decode_model.svh */
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

typedef struct packed {
    logic                     valid;
    logic                     rs1_read;
    logic                     rs2_read;
    logic                     rd_write;
    ctrl_pkg::imm_fmt_e       imm_fmt;
    ctrl_pkg::alu_op_e        alu_op;
    logic                     alu_sub_sra;
    ctrl_pkg::alu_src1_e      alu_src1;
    ctrl_pkg::alu_src2_e      alu_src2;
    logic                     mem_read;
    logic                     mem_write;
    ctrl_pkg::mem_width_e     mem_width;
    logic                     mem_zero_extend;
    logic                     mem_fence;
    logic                     csr_read;
    logic                     csr_write;
    ctrl_pkg::csr_write_op_e  csr_write_op;
    ctrl_pkg::csr_src_e       csr_src;
    ctrl_pkg::branch_op_e     branch_op;
    ctrl_pkg::branch_pc_src_e branch_pc_src;
} ctrl_fields_t;

function automatic ctrl_fields_t expected_ctrl(input logic [31:0] word);
    ctrl_fields_t c;
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       legal;
    c   = '0;
    opc = word[6:0];
    f3  = word[14:12];
    f7  = word[31:25];
    case (opc)
        rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC: begin
            c.valid    = 1'b1;
            c.rd_write = 1'b1;
            c.imm_fmt  = ctrl_pkg::IMM_U;
            c.alu_src1 = (opc == rv_isa_pkg::OPC_LUI) ? ctrl_pkg::SRC1_ZERO : ctrl_pkg::SRC1_PC;
            c.alu_src2 = ctrl_pkg::SRC2_IMM;
        end
        rv_isa_pkg::OPC_JAL, rv_isa_pkg::OPC_JALR: begin
            if (opc == rv_isa_pkg::OPC_JAL || f3 == 3'd0) begin
                c.valid     = 1'b1;
                c.rd_write  = 1'b1;
                c.alu_src1  = ctrl_pkg::SRC1_PC;
                c.alu_src2  = ctrl_pkg::SRC2_FOUR;
                c.branch_op = ctrl_pkg::BR_ALWAYS;
                if (opc == rv_isa_pkg::OPC_JALR) begin
                    c.rs1_read      = 1'b1;
                    c.imm_fmt       = ctrl_pkg::IMM_I;
                    c.branch_pc_src = ctrl_pkg::PC_SRC_REG;
                end else begin
                    c.imm_fmt = ctrl_pkg::IMM_J;
                end
            end
        end
        rv_isa_pkg::OPC_BRANCH: begin
            if (f3 != 3'd2 && f3 != 3'd3) begin
                c.valid       = 1'b1;
                c.rs1_read    = 1'b1;
                c.rs2_read    = 1'b1;
                c.imm_fmt     = ctrl_pkg::IMM_B;
                c.alu_sub_sra = 1'b1;
                case (f3)
                    3'd4, 3'd5: c.alu_op = ctrl_pkg::ALU_SLT;
                    3'd6, 3'd7: c.alu_op = ctrl_pkg::ALU_SLTU;
                    default:    c.alu_op = ctrl_pkg::ALU_ADD_SUB;
                endcase
                case (f3)
                    3'd1, 3'd4, 3'd6: c.branch_op = ctrl_pkg::BR_NON_ZERO;
                    default:          c.branch_op = ctrl_pkg::BR_ZERO;
                endcase
            end
        end
        rv_isa_pkg::OPC_LOAD, rv_isa_pkg::OPC_STORE: begin
            if (opc == rv_isa_pkg::OPC_LOAD) begin
                legal = f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd2 || f3 == 3'd4 || f3 == 3'd5;
            end else begin
                legal = f3 <= 3'd2;
            end
            if (legal) begin
                c.valid     = 1'b1;
                c.rs1_read  = 1'b1;
                c.alu_src2  = ctrl_pkg::SRC2_IMM;
                c.mem_width = ctrl_pkg::mem_width_e'(f3[1:0]);
                if (opc == rv_isa_pkg::OPC_LOAD) begin
                    c.rd_write        = 1'b1;
                    c.imm_fmt         = ctrl_pkg::IMM_I;
                    c.mem_read        = 1'b1;
                    c.mem_zero_extend = f3[2];
                end else begin
                    c.rs2_read  = 1'b1;
                    c.imm_fmt   = ctrl_pkg::IMM_S;
                    c.mem_write = 1'b1;
                end
            end
        end
        rv_isa_pkg::OPC_OP_IMM: begin
            if (f3 == 3'd1) legal = f7 == rv_isa_pkg::F7_BASE;
            else if (f3 == 3'd5) legal = f7 == rv_isa_pkg::F7_BASE || f7 == rv_isa_pkg::F7_ALT;
            else legal = 1'b1;
            if (legal) begin
                c.valid       = 1'b1;
                c.rs1_read    = 1'b1;
                c.rd_write    = 1'b1;
                c.imm_fmt     = (f3 == 3'd1 || f3 == 3'd5) ? ctrl_pkg::IMM_SHAMT : ctrl_pkg::IMM_I;
                c.alu_op      = ctrl_pkg::alu_op_e'(f3);
                c.alu_sub_sra = (f3 == 3'd5 && f7 == rv_isa_pkg::F7_ALT) || f3 == 3'd2
                             || f3 == 3'd3; // srai and slti(u).
                c.alu_src2    = ctrl_pkg::SRC2_IMM;
            end
        end
        rv_isa_pkg::OPC_OP: begin
            legal = f7 == rv_isa_pkg::F7_BASE
                 || (f7 == rv_isa_pkg::F7_ALT && (f3 == 3'd0 || f3 == 3'd5));
            if (legal) begin
                c.valid       = 1'b1;
                c.rs1_read    = 1'b1;
                c.rs2_read    = 1'b1;
                c.rd_write    = 1'b1;
                c.alu_op      = ctrl_pkg::alu_op_e'(f3);
                c.alu_sub_sra = f7 == rv_isa_pkg::F7_ALT || f3 == 3'd2 || f3 == 3'd3;
            end
        end
        rv_isa_pkg::OPC_MISC_MEM: begin
            c.valid     = f3 == 3'd0 || f3 == 3'd1;
            c.mem_fence = f3 == 3'd1; // fence.i only.
        end
        rv_isa_pkg::OPC_SYSTEM: begin
            if (f3 == 3'd0) begin
                c.valid = word == rv_isa_pkg::ECALL_WORD || word == rv_isa_pkg::EBREAK_WORD
                       || word == rv_isa_pkg::MRET_WORD || word == rv_isa_pkg::WFI_WORD;
            end else if (f3 != 3'd4) begin
                c.valid    = 1'b1;
                c.rs1_read = !f3[2];
                c.imm_fmt  = f3[2] ? ctrl_pkg::IMM_ZIMM : ctrl_pkg::IMM_NONE;
                c.csr_src  = f3[2] ? ctrl_pkg::CSR_SRC_IMM : ctrl_pkg::CSR_SRC_REG;
                case (f3[1:0])
                    2'd2:    c.csr_write_op = ctrl_pkg::CSR_RS;
                    2'd3:    c.csr_write_op = ctrl_pkg::CSR_RC;
                    default: c.csr_write_op = ctrl_pkg::CSR_RW;
                endcase
                if (f3[1:0] == 2'd1) begin
                    c.csr_read  = word[11:7] != 5'd0;
                    c.csr_write = 1'b1;
                end else begin
                    c.csr_read  = 1'b1;
                    c.csr_write = word[19:15] != 5'd0;
                end
                c.rd_write = c.csr_read;
            end
        end
        default: ;
    endcase
    return c;
endfunction

`endif

/* dv/control_unit_tb.sv */
`timescale 1ns/1ns

module control_unit_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int RANDOM_COUNT = 2000;

    logic clk;
    logic reset;
    rv_isa_pkg::instr_t instr;

    logic valid, rs1_read, rs2_read, rd_write, alu_sub_sra;
    logic mem_read, mem_write, mem_zero_extend, mem_fence, csr_read, csr_write;
    ctrl_pkg::imm_fmt_e       imm_fmt;
    ctrl_pkg::alu_op_e        alu_op;
    ctrl_pkg::alu_src1_e      alu_src1;
    ctrl_pkg::alu_src2_e      alu_src2;
    ctrl_pkg::mem_width_e     mem_width;
    ctrl_pkg::csr_write_op_e  csr_write_op;
    ctrl_pkg::csr_src_e       csr_src;
    ctrl_pkg::branch_op_e     branch_op;
    ctrl_pkg::branch_pc_src_e branch_pc_src;

    logic [31:0] directed[$];
    bit vectors_ready;
    int checks;
    int errors;

    `include "decode_model.svh"

    control_unit uut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] encode_word(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
            input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [6:0] major_opcode(input logic [3:0] sel);
        case (sel)
            4'd0:    return rv_isa_pkg::OPC_LUI;
            4'd1:    return rv_isa_pkg::OPC_AUIPC;
            4'd2:    return rv_isa_pkg::OPC_JAL;
            4'd3:    return rv_isa_pkg::OPC_JALR;
            4'd4:    return rv_isa_pkg::OPC_BRANCH;
            4'd5:    return rv_isa_pkg::OPC_LOAD;
            4'd6:    return rv_isa_pkg::OPC_STORE;
            4'd7:    return rv_isa_pkg::OPC_OP_IMM;
            4'd8:    return rv_isa_pkg::OPC_OP;
            4'd9:    return rv_isa_pkg::OPC_MISC_MEM;
            default: return rv_isa_pkg::OPC_SYSTEM;
        endcase
    endfunction

    task automatic build_directed();
        logic [6:0] f7;
        // words that must decode to nothing.
        directed.push_back(32'h0000_0000);
        directed.push_back(encode_word(7'h01, 5'd2, 5'd1, 3'd0, 5'd3, rv_isa_pkg::OPC_OP));
        directed.push_back(encode_word(7'h00, 5'd0, 5'd1, 3'd3, 5'd2, rv_isa_pkg::OPC_LOAD));
        directed.push_back(32'h0020_0073);
        directed.push_back(32'h1020_0073);
        directed.push_back(32'h0000_00f3);
        directed.push_back(rv_isa_pkg::ECALL_WORD);
        directed.push_back(rv_isa_pkg::EBREAK_WORD);
        directed.push_back(rv_isa_pkg::MRET_WORD);
        directed.push_back(rv_isa_pkg::WFI_WORD);
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int k = 0; k < 3; k++) begin
                f7 = (k == 0) ? 7'h00 : (k == 1) ? 7'h20 : 7'h01;
                directed.push_back(encode_word(f7, 5'd9, 5'd1, 3'(f3), 5'd4, rv_isa_pkg::OPC_OP));
                directed.push_back(encode_word(f7, 5'd9, 5'd1, 3'(f3), 5'd4,
                                               rv_isa_pkg::OPC_OP_IMM));
            end
        end
        directed.push_back(encode_word(7'h12, 5'd3, 5'd4, 3'd5, 5'd6, rv_isa_pkg::OPC_LUI));
        directed.push_back(encode_word(7'h12, 5'd3, 5'd4, 3'd5, 5'd6, rv_isa_pkg::OPC_AUIPC));
        for (int f3 = 0; f3 < 8; f3++) begin
            directed.push_back(encode_word(7'h00, 5'd0, 5'd2, 3'(f3), 5'd5, rv_isa_pkg::OPC_LOAD));
            directed.push_back(encode_word(7'h00, 5'd6, 5'd2, 3'(f3), 5'd8, rv_isa_pkg::OPC_STORE));
            directed.push_back(encode_word(7'h00, 5'd6, 5'd2, 3'(f3), 5'd8,
                                           rv_isa_pkg::OPC_BRANCH));
        end
        directed.push_back(32'h0ff0_000f); // fence iorw, iorw.
        directed.push_back(32'h0000_100f);
        directed.push_back(32'h0000_200f);
        directed.push_back(32'h0080_00ef);
        directed.push_back(encode_word(7'h00, 5'd4, 5'd1, 3'd0, 5'd1, rv_isa_pkg::OPC_JALR));
        directed.push_back(encode_word(7'h00, 5'd4, 5'd1, 3'd1, 5'd1, rv_isa_pkg::OPC_JALR));
        // csr 0x300 with rd and rs1/zimm each zero or not.
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int k = 0; k < 4; k++) begin
                directed.push_back(encode_word(7'h18, 5'd0, k[0] ? 5'd7 : 5'd0, 3'(f3),
                                               k[1] ? 5'd5 : 5'd0, rv_isa_pkg::OPC_SYSTEM));
            end
        end
    endtask

    task automatic check_field(input string name, input logic [3:0] actual,
            input logic [3:0] expected);
        assert (actual === expected) else begin
            errors++;
            $display("error: %s expected %h actual %h for instr %h", name, expected, actual,
                     instr);
        end
    endtask

    always @(negedge clk) begin
        ctrl_fields_t want;
        if (reset) begin
            want = '0; // idle outputs while held in reset.
        end else begin
            want = expected_ctrl(instr);
        end
        checks++;
        check_field("valid", 4'(valid), 4'(want.valid));
        check_field("rs1_read", 4'(rs1_read), 4'(want.rs1_read));
        check_field("rs2_read", 4'(rs2_read), 4'(want.rs2_read));
        check_field("rd_write", 4'(rd_write), 4'(want.rd_write));
        check_field("imm_fmt", 4'(imm_fmt), 4'(want.imm_fmt));
        check_field("alu_op", 4'(alu_op), 4'(want.alu_op));
        check_field("alu_sub_sra", 4'(alu_sub_sra), 4'(want.alu_sub_sra));
        check_field("alu_src1", 4'(alu_src1), 4'(want.alu_src1));
        check_field("alu_src2", 4'(alu_src2), 4'(want.alu_src2));
        check_field("mem_read", 4'(mem_read), 4'(want.mem_read));
        check_field("mem_write", 4'(mem_write), 4'(want.mem_write));
        check_field("mem_width", 4'(mem_width), 4'(want.mem_width));
        check_field("mem_zero_extend", 4'(mem_zero_extend), 4'(want.mem_zero_extend));
        check_field("mem_fence", 4'(mem_fence), 4'(want.mem_fence));
        check_field("csr_read", 4'(csr_read), 4'(want.csr_read));
        check_field("csr_write", 4'(csr_write), 4'(want.csr_write));
        check_field("csr_write_op", 4'(csr_write_op), 4'(want.csr_write_op));
        check_field("csr_src", 4'(csr_src), 4'(want.csr_src));
        check_field("branch_op", 4'(branch_op), 4'(want.branch_op));
        check_field("branch_pc_src", 4'(branch_pc_src), 4'(want.branch_pc_src));
    end

    initial begin
        logic [31:0] seed;
        logic [31:0] word;
        logic [15:0] pick;
        clk   = 1'b0;
        reset = 1'b1;
        instr = '0;
        seed  = 32'h9753_ee01;
        build_directed();
        vectors_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        foreach (directed[i]) begin
            @(posedge clk);
            instr <= directed[i];
        end
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            seed = lcg_next(seed);
            word = seed;
            if (i % 2 == 0) begin // legal major opcode on every other word.
                seed = lcg_next(seed);
                pick = seed[31:16] % 16'd11;
                word[6:0] = major_opcode(pick[3:0]);
            end
            @(posedge clk);
            instr <= word;
        end
        @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        wait (vectors_ready);
        #((directed.size() + RANDOM_COUNT + 10) * CLK_PERIOD);
        $display("timeout: the stimulus did not complete in time");
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* list.f */
+incdir+include
verilog/rv_isa_pkg.sv
verilog/ctrl_pkg.sv
verilog/instr_class_decoder.sv
verilog/alu_ctrl_decoder.sv
verilog/mem_ctrl_decoder.sv
verilog/csr_ctrl_decoder.sv
verilog/control_unit.sv
dv/control_unit_tb.sv

/* verilog/alu_ctrl_decoder.sv */
`timescale 1ns/1ns

module alu_ctrl_decoder (
    input  rv_isa_pkg::instr_t       instr,
    input  ctrl_pkg::instr_class_e   instr_class,
    output ctrl_pkg::alu_op_e        alu_op,
    output logic                     alu_sub_sra,
    output ctrl_pkg::alu_src1_e      alu_src1,
    output ctrl_pkg::alu_src2_e      alu_src2
);

    rv_isa_pkg::funct3_t funct3;
    rv_isa_pkg::funct7_t funct7;
    logic alt_form;
    logic is_slt;

    assign funct3 = instr[rv_isa_pkg::FUNCT3_LSB +: 3];
    assign funct7 = instr[rv_isa_pkg::FUNCT7_LSB +: 7];

    // addi carries immediate bits in funct7.
    assign alt_form = funct7 == rv_isa_pkg::F7_ALT
                   && (funct3 == 3'd5 || (funct3 == 3'd0 && instr_class == ctrl_pkg::CLS_OP));
    assign is_slt   = funct3[2:1] == 2'b01;

    always_comb begin
        alu_op      = ctrl_pkg::ALU_ADD_SUB;
        alu_sub_sra = 1'b0;
        alu_src1    = ctrl_pkg::SRC1_REG;
        alu_src2    = ctrl_pkg::SRC2_REG;
        case (instr_class)
            ctrl_pkg::CLS_LUI: begin
                alu_src1 = ctrl_pkg::SRC1_ZERO;
                alu_src2 = ctrl_pkg::SRC2_IMM;
            end
            ctrl_pkg::CLS_AUIPC: begin
                alu_src1 = ctrl_pkg::SRC1_PC;
                alu_src2 = ctrl_pkg::SRC2_IMM;
            end
            ctrl_pkg::CLS_JAL, ctrl_pkg::CLS_JALR: begin
                alu_src1 = ctrl_pkg::SRC1_PC; // link address.
                alu_src2 = ctrl_pkg::SRC2_FOUR;
            end
            ctrl_pkg::CLS_BRANCH: begin
                alu_sub_sra = 1'b1;
                case (funct3[2:1])
                    2'b10:   alu_op = ctrl_pkg::ALU_SLT;
                    2'b11:   alu_op = ctrl_pkg::ALU_SLTU;
                    default: alu_op = ctrl_pkg::ALU_ADD_SUB;
                endcase
            end
            ctrl_pkg::CLS_LOAD, ctrl_pkg::CLS_STORE: begin
                alu_src2 = ctrl_pkg::SRC2_IMM;
            end
            ctrl_pkg::CLS_OP_IMM: begin
                alu_op      = ctrl_pkg::alu_op_e'(funct3);
                alu_sub_sra = alt_form || is_slt;
                alu_src2    = ctrl_pkg::SRC2_IMM;
            end
            ctrl_pkg::CLS_OP: begin
                alu_op      = ctrl_pkg::alu_op_e'(funct3);
                alu_sub_sra = alt_form || is_slt;
            end
            default: ;
        endcase
    end

endmodule

/* verilog/control_unit.sv */
`timescale 1ns/1ns

module control_unit (
    input  rv_isa_pkg::instr_t           instr,
    output logic                         valid,
    output logic                         rs1_read,
    output logic                         rs2_read,
    output logic                         rd_write,
    output ctrl_pkg::imm_fmt_e           imm_fmt,
    output ctrl_pkg::alu_op_e            alu_op,
    output logic                         alu_sub_sra,
    output ctrl_pkg::alu_src1_e          alu_src1,
    output ctrl_pkg::alu_src2_e          alu_src2,
    output logic                         mem_read,
    output logic                         mem_write,
    output ctrl_pkg::mem_width_e         mem_width,
    output logic                         mem_zero_extend,
    output logic                         mem_fence,
    output logic                         csr_read,
    output logic                         csr_write,
    output ctrl_pkg::csr_write_op_e      csr_write_op,
    output ctrl_pkg::csr_src_e           csr_src,
    output ctrl_pkg::branch_op_e         branch_op,
    output ctrl_pkg::branch_pc_src_e     branch_pc_src
);

    ctrl_pkg::instr_class_e instr_class;

    instr_class_decoder u_class (
        .instr         (instr),
        .csr_read      (csr_read),
        .instr_class   (instr_class),
        .valid         (valid),
        .rs1_read      (rs1_read),
        .rs2_read      (rs2_read),
        .rd_write      (rd_write),
        .mem_fence     (mem_fence),
        .imm_fmt       (imm_fmt),
        .branch_op     (branch_op),
        .branch_pc_src (branch_pc_src)
    );

    alu_ctrl_decoder u_alu (
        .instr       (instr),
        .instr_class (instr_class),
        .alu_op      (alu_op),
        .alu_sub_sra (alu_sub_sra),
        .alu_src1    (alu_src1),
        .alu_src2    (alu_src2)
    );

    mem_ctrl_decoder u_mem (
        .instr           (instr),
        .instr_class     (instr_class),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_zero_extend (mem_zero_extend),
        .mem_width       (mem_width)
    );

    csr_ctrl_decoder u_csr (
        .instr        (instr),
        .instr_class  (instr_class),
        .csr_read     (csr_read),
        .csr_write    (csr_write),
        .csr_write_op (csr_write_op),
        .csr_src      (csr_src)
    );

endmodule

/* verilog/csr_ctrl_decoder.sv */
`timescale 1ns/1ns

module csr_ctrl_decoder (
    input  rv_isa_pkg::instr_t       instr,
    input  ctrl_pkg::instr_class_e   instr_class,
    output logic                     csr_read,
    output logic                     csr_write,
    output ctrl_pkg::csr_write_op_e  csr_write_op,
    output ctrl_pkg::csr_src_e       csr_src
);

    rv_isa_pkg::funct3_t  funct3;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::reg_idx_t rs1; // zimm in the immediate forms.
    logic is_csr;
    logic rw_form;

    assign funct3  = instr[rv_isa_pkg::FUNCT3_LSB +: 3];
    assign rd      = instr[rv_isa_pkg::RD_LSB +: 5];
    assign rs1     = instr[rv_isa_pkg::RS1_LSB +: 5];
    assign is_csr  = instr_class == ctrl_pkg::CLS_CSR;
    assign rw_form = funct3[1:0] == 2'b01;

    always_comb begin
        csr_read     = 1'b0;
        csr_write    = 1'b0;
        csr_write_op = ctrl_pkg::CSR_RW;
        csr_src      = ctrl_pkg::CSR_SRC_REG;
        if (is_csr) begin
            csr_write_op = ctrl_pkg::csr_write_op_e'(funct3[1:0] - 2'd1);
            csr_src      = funct3[2] ? ctrl_pkg::CSR_SRC_IMM : ctrl_pkg::CSR_SRC_REG;
            if (rw_form) begin
                csr_read  = rd != 5'd0; // no read side effects for rd = x0.
                csr_write = 1'b1;
            end else begin
                csr_read  = 1'b1;
                csr_write = rs1 != 5'd0; // set/clear with zero mask writes nothing.
            end
        end
    end

endmodule

/* verilog/ctrl_pkg.sv */
package ctrl_pkg;

    typedef enum logic [3:0] {
        CLS_NONE,
        CLS_LUI,
        CLS_AUIPC,
        CLS_JAL,
        CLS_JALR,
        CLS_BRANCH,
        CLS_LOAD,
        CLS_STORE,
        CLS_OP_IMM,
        CLS_OP,
        CLS_FENCE,
        CLS_FENCE_I,
        CLS_SYSTEM, // ecall, ebreak, mret, wfi.
        CLS_CSR
    } instr_class_e;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_SHAMT,
        IMM_ZIMM
    } imm_fmt_e;

    // same order as funct3 of OP.
    typedef enum logic [2:0] {
        ALU_ADD_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {SRC1_REG, SRC1_PC, SRC1_ZERO} alu_src1_e;
    typedef enum logic [1:0] {SRC2_REG, SRC2_IMM, SRC2_FOUR} alu_src2_e;

    typedef enum logic [1:0] {WIDTH_BYTE, WIDTH_HALF, WIDTH_WORD} mem_width_e;

    // taken condition on the alu result.
    typedef enum logic [1:0] {
        BR_NEVER,
        BR_ZERO,
        BR_NON_ZERO,
        BR_ALWAYS
    } branch_op_e;

    typedef enum logic {PC_SRC_IMM, PC_SRC_REG} branch_pc_src_e;

    typedef enum logic [1:0] {CSR_RW, CSR_RS, CSR_RC} csr_write_op_e;

    typedef enum logic {CSR_SRC_REG, CSR_SRC_IMM} csr_src_e;

endpackage

/* verilog/instr_class_decoder.sv */
`timescale 1ns/1ns

module instr_class_decoder (
    input  rv_isa_pkg::instr_t           instr,
    input  logic                         csr_read,
    output ctrl_pkg::instr_class_e       instr_class,
    output logic                         valid,
    output logic                         rs1_read,
    output logic                         rs2_read,
    output logic                         rd_write,
    output logic                         mem_fence,
    output ctrl_pkg::imm_fmt_e           imm_fmt,
    output ctrl_pkg::branch_op_e         branch_op,
    output ctrl_pkg::branch_pc_src_e     branch_pc_src
);

    rv_isa_pkg::opcode_t opcode;
    rv_isa_pkg::funct3_t funct3;
    rv_isa_pkg::funct7_t funct7;
    logic f7_base;
    logic f7_alt;
    logic op_ok;
    logic op_imm_ok;
    logic sys_word;

    assign opcode  = instr[6:0];
    assign funct3  = instr[rv_isa_pkg::FUNCT3_LSB +: 3];
    assign funct7  = instr[rv_isa_pkg::FUNCT7_LSB +: 7];
    assign f7_base = funct7 == rv_isa_pkg::F7_BASE;
    assign f7_alt  = funct7 == rv_isa_pkg::F7_ALT;

    // alt form only for add/sub and srl/sra.
    assign op_ok = f7_base || (f7_alt && (funct3 == 3'd0 || funct3 == 3'd5));

    always_comb begin
        case (funct3)
            3'd1:    op_imm_ok = f7_base; // slli.
            3'd5:    op_imm_ok = f7_base || f7_alt; // srli, srai.
            default: op_imm_ok = 1'b1;
        endcase
    end

    assign sys_word = instr == rv_isa_pkg::ECALL_WORD || instr == rv_isa_pkg::EBREAK_WORD
                   || instr == rv_isa_pkg::MRET_WORD || instr == rv_isa_pkg::WFI_WORD;

    always_comb begin
        instr_class = ctrl_pkg::CLS_NONE;
        case (opcode)
            rv_isa_pkg::OPC_LUI:   instr_class = ctrl_pkg::CLS_LUI;
            rv_isa_pkg::OPC_AUIPC: instr_class = ctrl_pkg::CLS_AUIPC;
            rv_isa_pkg::OPC_JAL:   instr_class = ctrl_pkg::CLS_JAL;
            rv_isa_pkg::OPC_JALR: begin
                if (funct3 == 3'd0) instr_class = ctrl_pkg::CLS_JALR;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                if (funct3[2:1] != 2'b01) instr_class = ctrl_pkg::CLS_BRANCH;
            end
            rv_isa_pkg::OPC_LOAD: begin
                if (funct3 != 3'd3 && funct3 < 3'd6) instr_class = ctrl_pkg::CLS_LOAD;
            end
            rv_isa_pkg::OPC_STORE: begin
                if (funct3 < 3'd3) instr_class = ctrl_pkg::CLS_STORE;
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                if (op_imm_ok) instr_class = ctrl_pkg::CLS_OP_IMM;
            end
            rv_isa_pkg::OPC_OP: begin
                if (op_ok) instr_class = ctrl_pkg::CLS_OP;
            end
            rv_isa_pkg::OPC_MISC_MEM: begin
                if (funct3 == 3'd0) instr_class = ctrl_pkg::CLS_FENCE;
                else if (funct3 == 3'd1) instr_class = ctrl_pkg::CLS_FENCE_I;
            end
            rv_isa_pkg::OPC_SYSTEM: begin
                if (funct3 == 3'd0) begin
                    if (sys_word) instr_class = ctrl_pkg::CLS_SYSTEM;
                end else if (funct3 != 3'd4) begin
                    instr_class = ctrl_pkg::CLS_CSR;
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        rs1_read      = 1'b0;
        rs2_read      = 1'b0;
        rd_write      = 1'b0;
        imm_fmt       = ctrl_pkg::IMM_NONE;
        branch_op     = ctrl_pkg::BR_NEVER;
        branch_pc_src = ctrl_pkg::PC_SRC_IMM;
        case (instr_class)
            ctrl_pkg::CLS_LUI, ctrl_pkg::CLS_AUIPC: begin
                rd_write = 1'b1;
                imm_fmt  = ctrl_pkg::IMM_U;
            end
            ctrl_pkg::CLS_JAL: begin
                rd_write  = 1'b1;
                imm_fmt   = ctrl_pkg::IMM_J;
                branch_op = ctrl_pkg::BR_ALWAYS;
            end
            ctrl_pkg::CLS_JALR: begin
                rs1_read      = 1'b1;
                rd_write      = 1'b1;
                imm_fmt       = ctrl_pkg::IMM_I;
                branch_op     = ctrl_pkg::BR_ALWAYS;
                branch_pc_src = ctrl_pkg::PC_SRC_REG;
            end
            ctrl_pkg::CLS_BRANCH: begin
                rs1_read  = 1'b1;
                rs2_read  = 1'b1;
                imm_fmt   = ctrl_pkg::IMM_B;
                // bne, blt, bltu take on a non-zero compare.
                branch_op = (funct3[0] ^ funct3[2]) ? ctrl_pkg::BR_NON_ZERO : ctrl_pkg::BR_ZERO;
            end
            ctrl_pkg::CLS_LOAD: begin
                rs1_read = 1'b1;
                rd_write = 1'b1;
                imm_fmt  = ctrl_pkg::IMM_I;
            end
            ctrl_pkg::CLS_STORE: begin
                rs1_read = 1'b1;
                rs2_read = 1'b1;
                imm_fmt  = ctrl_pkg::IMM_S;
            end
            ctrl_pkg::CLS_OP_IMM: begin
                rs1_read = 1'b1;
                rd_write = 1'b1;
                imm_fmt  = (funct3[1:0] == 2'b01) ? ctrl_pkg::IMM_SHAMT : ctrl_pkg::IMM_I;
            end
            ctrl_pkg::CLS_OP: begin
                rs1_read = 1'b1;
                rs2_read = 1'b1;
                rd_write = 1'b1;
            end
            ctrl_pkg::CLS_CSR: begin
                rs1_read = !funct3[2]; // register form.
                rd_write = csr_read;
                imm_fmt  = funct3[2] ? ctrl_pkg::IMM_ZIMM : ctrl_pkg::IMM_NONE;
            end
            default: ;
        endcase
    end

    assign valid     = instr_class != ctrl_pkg::CLS_NONE;
    assign mem_fence = instr_class == ctrl_pkg::CLS_FENCE_I;

endmodule

/* verilog/mem_ctrl_decoder.sv */
`timescale 1ns/1ns

module mem_ctrl_decoder (
    input  rv_isa_pkg::instr_t       instr,
    input  ctrl_pkg::instr_class_e   instr_class,
    output logic                     mem_read,
    output logic                     mem_write,
    output logic                     mem_zero_extend,
    output ctrl_pkg::mem_width_e     mem_width
);

    rv_isa_pkg::funct3_t funct3;

    assign funct3 = instr[rv_isa_pkg::FUNCT3_LSB +: 3];

    assign mem_read  = instr_class == ctrl_pkg::CLS_LOAD;
    assign mem_write = instr_class == ctrl_pkg::CLS_STORE;

    // lbu and lhu.
    assign mem_zero_extend = mem_read && funct3[2];

    assign mem_width = (mem_read || mem_write) ? ctrl_pkg::mem_width_e'(funct3[1:0])
                                               : ctrl_pkg::WIDTH_BYTE;

endmodule

/* verilog/rv_isa_pkg.sv */
package rv_isa_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // major opcodes, low two bits always 11.
    localparam opcode_t OPC_LUI      = 7'b0110111;
    localparam opcode_t OPC_AUIPC    = 7'b0010111;
    localparam opcode_t OPC_JAL      = 7'b1101111;
    localparam opcode_t OPC_JALR     = 7'b1100111;
    localparam opcode_t OPC_BRANCH   = 7'b1100011;
    localparam opcode_t OPC_LOAD     = 7'b0000011;
    localparam opcode_t OPC_STORE    = 7'b0100011;
    localparam opcode_t OPC_OP_IMM   = 7'b0010011;
    localparam opcode_t OPC_OP       = 7'b0110011;
    localparam opcode_t OPC_MISC_MEM = 7'b0001111;
    localparam opcode_t OPC_SYSTEM   = 7'b1110011;

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000; // sub and sra.

    // complete words of the funct3 = 0 system instructions.
    localparam instr_t ECALL_WORD  = 32'h0000_0073;
    localparam instr_t EBREAK_WORD = 32'h0010_0073;
    localparam instr_t MRET_WORD   = 32'h3020_0073;
    localparam instr_t WFI_WORD    = 32'h1050_0073;

    localparam logic [4:0] RD_LSB     = 5'd7;
    localparam logic [4:0] FUNCT3_LSB = 5'd12;
    localparam logic [4:0] RS1_LSB    = 5'd15;
    localparam logic [4:0] FUNCT7_LSB = 5'd25;

endpackage
